// ==== logic/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    typedef logic [31:0] wordT;   // data or address word
    typedef logic [4:0]  regIdxT;
    typedef logic [6:0]  opcodeT;

    // major opcodes of the supported subset
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opIType  = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;

    localparam logic [2:0] f3AddSub = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam wordT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== logic/rvPipePkg.sv ====
`default_nettype none

package rvPipePkg;

    typedef logic [2:0] aluCtrlT;
    typedef logic [1:0] resultSrcT;
    typedef logic [1:0] immSrcT;

    localparam aluCtrlT aluAdd = 3'b000;
    localparam aluCtrlT aluSub = 3'b001;
    localparam aluCtrlT aluAnd = 3'b010;
    localparam aluCtrlT aluOr  = 3'b011;
    localparam aluCtrlT aluSlt = 3'b101;

    // writeback result select
    localparam resultSrcT resAlu     = 2'b00;
    localparam resultSrcT resMem     = 2'b01;
    localparam resultSrcT resPcPlus4 = 2'b10;

    localparam immSrcT immI = 2'b00;
    localparam immSrcT immS = 2'b01;
    localparam immSrcT immB = 2'b10;
    localparam immSrcT immJ = 2'b11;

    localparam logic [31:0] pcStep = 32'd4;  // sequential fetch step

endpackage

`default_nettype wire

// ==== logic/stageIfs.sv ====
`default_nettype none

interface decodeExecuteIf;
    rvIsaPkg::wordT       rd1;
    rvIsaPkg::wordT       rd2;
    rvIsaPkg::wordT       immExt;
    rvIsaPkg::wordT       pc;
    rvIsaPkg::wordT       pcPlus4;
    rvIsaPkg::regIdxT     rd;
    logic                 regWrite;
    logic                 memWrite;
    logic                 jump;
    logic                 branch;
    logic                 aluSrc;
    rvPipePkg::resultSrcT resultSrc;
    rvPipePkg::aluCtrlT   aluControl;

    modport src (output rd1, rd2, immExt, pc, pcPlus4, rd, regWrite, memWrite,
                 jump, branch, aluSrc, resultSrc, aluControl);
    modport dst (input rd1, rd2, immExt, pc, pcPlus4, rd, regWrite, memWrite,
                 jump, branch, aluSrc, resultSrc, aluControl);
endinterface

interface executeMemIf;
    rvIsaPkg::wordT       aluResult;
    rvIsaPkg::wordT       writeData;
    rvIsaPkg::wordT       pcPlus4;
    rvIsaPkg::regIdxT     rd;
    logic                 regWrite;
    logic                 memWrite;
    rvPipePkg::resultSrcT resultSrc;

    modport src (output aluResult, writeData, pcPlus4, rd, regWrite, memWrite, resultSrc);
    modport dst (input aluResult, writeData, pcPlus4, rd, regWrite, memWrite, resultSrc);
endinterface

interface writebackIf;
    logic             regWrite;
    rvIsaPkg::regIdxT rd;
    rvIsaPkg::wordT   result;

    modport src (output regWrite, rd, result);
    modport dst (input regWrite, rd, result);
endinterface

`default_nettype wire

// ==== logic/fetchStage.sv ====
`default_nettype none

module fetchStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           pcSrc,
    input  rvIsaPkg::wordT pcTarget,
    input  rvIsaPkg::wordT imemData,
    output rvIsaPkg::wordT imemAddr,
    output rvIsaPkg::wordT instrD,
    output rvIsaPkg::wordT pcD,
    output rvIsaPkg::wordT pcPlus4D
);
    rvIsaPkg::wordT pcF;
    rvIsaPkg::wordT pcPlus4F;
    rvIsaPkg::wordT pcNext;

    assign pcPlus4F = pcF + rvPipePkg::pcStep;
    assign pcNext   = pcSrc ? pcTarget : pcPlus4F;  // redirect from execute
    assign imemAddr = pcF;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF    <= '0;
            instrD <= rvIsaPkg::nopInstr;
        end else begin
            pcF    <= pcNext;
            instrD <= pcSrc ? rvIsaPkg::nopInstr : imemData;  // kill younger fetch
        end
    end

    always_ff @(posedge clk) begin
        pcD      <= pcF;
        pcPlus4D <= pcPlus4F;
    end

endmodule

`default_nettype wire

// ==== logic/controlDecoder.sv ====
`default_nettype none

module controlDecoder (
    input  rvIsaPkg::opcodeT      opcode,
    input  logic [2:0]            funct3,
    input  logic                  funct7b5,
    output logic                  regWrite,
    output logic                  memWrite,
    output logic                  branch,
    output logic                  jump,
    output logic                  aluSrc,
    output rvPipePkg::resultSrcT  resultSrc,
    output rvPipePkg::immSrcT     immSrc,
    output rvPipePkg::aluCtrlT    aluControl
);
    logic [1:0] aluOp;  // 00 add, 01 sub, 10 by funct3
    logic       rTypeSub;

    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        aluSrc    = 1'b0;
        resultSrc = rvPipePkg::resAlu;
        immSrc    = rvPipePkg::immI;
        aluOp     = 2'b00;
        case (opcode)
            rvIsaPkg::opRType: begin
                regWrite = 1'b1;
                aluOp    = 2'b10;
            end
            rvIsaPkg::opIType: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = 2'b10;
            end
            rvIsaPkg::opLoad: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = rvPipePkg::resMem;
            end
            rvIsaPkg::opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = rvPipePkg::immS;
            end
            rvIsaPkg::opBranch: begin
                branch = 1'b1;
                immSrc = rvPipePkg::immB;
                aluOp  = 2'b01;  // compare by subtraction
            end
            rvIsaPkg::opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = rvPipePkg::immJ;
                resultSrc = rvPipePkg::resPcPlus4;
            end
            default: ;
        endcase
    end

    // addi has no sub form, bit 30 is immediate there
    assign rTypeSub = funct7b5 && (opcode == rvIsaPkg::opRType);

    always_comb begin
        case (aluOp)
            2'b01: aluControl = rvPipePkg::aluSub;
            2'b10: begin
                case (funct3)
                    rvIsaPkg::f3AddSub: aluControl = rTypeSub ? rvPipePkg::aluSub
                                                              : rvPipePkg::aluAdd;
                    rvIsaPkg::f3Slt:    aluControl = rvPipePkg::aluSlt;
                    rvIsaPkg::f3Or:     aluControl = rvPipePkg::aluOr;
                    rvIsaPkg::f3And:    aluControl = rvPipePkg::aluAnd;
                    default:            aluControl = rvPipePkg::aluAdd;
                endcase
            end
            default: aluControl = rvPipePkg::aluAdd;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`default_nettype none

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  rvIsaPkg::regIdxT rs1,
    input  rvIsaPkg::regIdxT rs2,
    writebackIf.dst          wb,
    output rvIsaPkg::wordT   rd1,
    output rvIsaPkg::wordT   rd2
);
    rvIsaPkg::wordT regs [32];
    logic           wrEn;

    assign wrEn = wb.regWrite && (wb.rd != '0);  // x0 never written

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Writeback data bypasses the array so decode sees it in the same cycle.
    assign rd1 = (rs1 == '0) ? '0 :
                 (wrEn && (wb.rd == rs1)) ? wb.result : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 :
                 (wrEn && (wb.rd == rs2)) ? wb.result : regs[rs2];

endmodule

`default_nettype wire

// ==== logic/decodeStage.sv ====
`default_nettype none

module decodeStage (
    input  logic           clk,
    input  logic           rstN,
    input  rvIsaPkg::wordT instrD,
    input  rvIsaPkg::wordT pcD,
    input  rvIsaPkg::wordT pcPlus4D,
    input  logic           flush,
    writebackIf.dst        wb,
    decodeExecuteIf.src    de
);
    rvIsaPkg::wordT       rd1D;
    rvIsaPkg::wordT       rd2D;
    rvIsaPkg::wordT       immExtD;
    logic                 regWriteD;
    logic                 memWriteD;
    logic                 branchD;
    logic                 jumpD;
    logic                 aluSrcD;
    rvPipePkg::resultSrcT resultSrcD;
    rvPipePkg::immSrcT    immSrcD;
    rvPipePkg::aluCtrlT   aluControlD;

    controlDecoder ctrlDec (
        .opcode     (instrD[6:0]),
        .funct3     (instrD[14:12]),
        .funct7b5   (instrD[30]),
        .regWrite   (regWriteD),
        .memWrite   (memWriteD),
        .branch     (branchD),
        .jump       (jumpD),
        .aluSrc     (aluSrcD),
        .resultSrc  (resultSrcD),
        .immSrc     (immSrcD),
        .aluControl (aluControlD)
    );

    regFile rf (
        .clk  (clk),
        .rstN (rstN),
        .rs1  (instrD[19:15]),
        .rs2  (instrD[24:20]),
        .wb   (wb),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

    always_comb begin
        case (immSrcD)
            rvPipePkg::immS: immExtD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            rvPipePkg::immB: immExtD = {{20{instrD[31]}}, instrD[7], instrD[30:25],
                                        instrD[11:8], 1'b0};
            rvPipePkg::immJ: immExtD = {{12{instrD[31]}}, instrD[19:12], instrD[20],
                                        instrD[30:21], 1'b0};
            default:         immExtD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // ID/EX control, bubble on reset or flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            de.regWrite   <= 1'b0;
            de.memWrite   <= 1'b0;
            de.jump       <= 1'b0;
            de.branch     <= 1'b0;
            de.aluSrc     <= 1'b0;
            de.resultSrc  <= rvPipePkg::resAlu;
            de.aluControl <= rvPipePkg::aluAdd;
        end else if (flush) begin
            de.regWrite   <= 1'b0;
            de.memWrite   <= 1'b0;
            de.jump       <= 1'b0;
            de.branch     <= 1'b0;
            de.aluSrc     <= 1'b0;
            de.resultSrc  <= rvPipePkg::resAlu;
            de.aluControl <= rvPipePkg::aluAdd;
        end else begin
            de.regWrite   <= regWriteD;
            de.memWrite   <= memWriteD;
            de.jump       <= jumpD;
            de.branch     <= branchD;
            de.aluSrc     <= aluSrcD;
            de.resultSrc  <= resultSrcD;
            de.aluControl <= aluControlD;
        end
    end

    always_ff @(posedge clk) begin
        de.rd1     <= rd1D;
        de.rd2     <= rd2D;
        de.immExt  <= immExtD;
        de.pc      <= pcD;
        de.pcPlus4 <= pcPlus4D;
        de.rd      <= instrD[11:7];
    end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
`default_nettype none

module executeStage (
    input  logic           clk,
    input  logic           rstN,
    decodeExecuteIf.dst    de,
    executeMemIf.src       em,
    output logic           pcSrc,
    output rvIsaPkg::wordT pcTarget
);
    rvIsaPkg::wordT srcB;
    rvIsaPkg::wordT aluResult;
    logic           zero;

    assign srcB = de.aluSrc ? de.immExt : de.rd2;

    always_comb begin
        case (de.aluControl)
            rvPipePkg::aluSub: aluResult = de.rd1 - srcB;
            rvPipePkg::aluAnd: aluResult = de.rd1 & srcB;
            rvPipePkg::aluOr:  aluResult = de.rd1 | srcB;
            rvPipePkg::aluSlt: aluResult = {31'b0, $signed(de.rd1) < $signed(srcB)};
            default:           aluResult = de.rd1 + srcB;
        endcase
    end

    assign zero     = (aluResult == '0);
    assign pcSrc    = de.jump | (de.branch & zero);  // beq taken or jal
    assign pcTarget = de.pc + de.immExt;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            em.regWrite  <= 1'b0;
            em.memWrite  <= 1'b0;
            em.resultSrc <= rvPipePkg::resAlu;
        end else begin
            em.regWrite  <= de.regWrite;
            em.memWrite  <= de.memWrite;
            em.resultSrc <= de.resultSrc;
        end
    end

    always_ff @(posedge clk) begin
        em.aluResult <= aluResult;
        em.writeData <= de.rd2;  // store data, never the immediate
        em.pcPlus4   <= de.pcPlus4;
        em.rd        <= de.rd;
    end

endmodule

`default_nettype wire

// ==== logic/memWbStage.sv ====
`default_nettype none

module memWbStage (
    input  logic           clk,
    input  logic           rstN,
    executeMemIf.dst       em,
    input  rvIsaPkg::wordT dmemReadData,
    output rvIsaPkg::wordT dmemAddr,
    output rvIsaPkg::wordT dmemWriteData,
    output logic           dmemWrite,
    writebackIf.src        wb
);
    rvIsaPkg::wordT       aluResultW;
    rvIsaPkg::wordT       readDataW;
    rvIsaPkg::wordT       pcPlus4W;
    rvPipePkg::resultSrcT resultSrcW;

    assign dmemAddr      = em.aluResult;
    assign dmemWriteData = em.writeData;
    assign dmemWrite     = em.memWrite;  // memory writes at next edge

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wb.regWrite <= 1'b0;
            resultSrcW  <= rvPipePkg::resAlu;
        end else begin
            wb.regWrite <= em.regWrite;
            resultSrcW  <= em.resultSrc;
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= em.aluResult;
        readDataW  <= dmemReadData;
        pcPlus4W   <= em.pcPlus4;
        wb.rd      <= em.rd;
    end

    always_comb begin
        case (resultSrcW)
            rvPipePkg::resMem:     wb.result = readDataW;
            rvPipePkg::resPcPlus4: wb.result = pcPlus4W;  // jal link
            default:               wb.result = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/rv32iCore.sv ====
`default_nettype none

module rv32iCore (
    input  logic           clk,
    input  logic           rstN,
    output rvIsaPkg::wordT imemAddr,
    input  rvIsaPkg::wordT imemData,
    output rvIsaPkg::wordT dmemAddr,
    output rvIsaPkg::wordT dmemWriteData,
    output logic           dmemWrite,
    input  rvIsaPkg::wordT dmemReadData
);
    logic           pcSrc;
    rvIsaPkg::wordT pcTarget;
    rvIsaPkg::wordT instrD;
    rvIsaPkg::wordT pcD;
    rvIsaPkg::wordT pcPlus4D;

    decodeExecuteIf deBus ();
    executeMemIf    emBus ();
    writebackIf     wbBus ();

    fetchStage fetchInst (
        .clk      (clk),
        .rstN     (rstN),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .instrD   (instrD),
        .pcD      (pcD),
        .pcPlus4D (pcPlus4D)
    );

    decodeStage decodeInst (
        .clk      (clk),
        .rstN     (rstN),
        .instrD   (instrD),
        .pcD      (pcD),
        .pcPlus4D (pcPlus4D),
        .flush    (pcSrc),  // taken branch or jal
        .wb       (wbBus),
        .de       (deBus)
    );

    executeStage executeInst (
        .clk      (clk),
        .rstN     (rstN),
        .de       (deBus),
        .em       (emBus),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget)
    );

    memWbStage memWbInst (
        .clk           (clk),
        .rstN          (rstN),
        .em            (emBus),
        .dmemReadData  (dmemReadData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .wb            (wbBus)
    );

endmodule

`default_nettype wire

// ==== dv/rv32iCoreTb.sv ====
`default_nettype none

module rv32iCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int kindAddi = 0;
    localparam int kindAndi = 1;
    localparam int kindOri  = 2;
    localparam int kindSlti = 3;
    localparam int kindAdd  = 4;  // register forms from here on
    localparam int kindSub  = 5;
    localparam int kindAnd  = 6;
    localparam int kindOr   = 7;
    localparam int kindSlt  = 8;

    localparam int numArith     = 12;
    localparam int storeTimeout = 200;  // cycles per store
    localparam int quietCycles  = 30;
    localparam int skipBase     = 'h3f0;  // targets of stores that must be skipped
    localparam logic [2:0] f3Word = 3'b010;
    localparam logic [2:0] f3Beq  = 3'b000;

    logic           clk;
    logic           rstN;
    rvIsaPkg::wordT imemAddr;
    rvIsaPkg::wordT imemData;
    rvIsaPkg::wordT dmemAddr;
    rvIsaPkg::wordT dmemWriteData;
    logic           dmemWrite;
    rvIsaPkg::wordT dmemReadData;

    rvIsaPkg::wordT imem [256];
    rvIsaPkg::wordT dmem [256];
    rvIsaPkg::wordT prog [$];
    rvIsaPkg::wordT expAddr [$];
    rvIsaPkg::wordT expData [$];
    int             errors;
    int             nextAddr;

    // kind with operand a in x1 and operand b as immediate or in x3
    int arithKind [numArith] = '{kindAddi, kindAddi, kindAndi, kindOri, kindSlti, kindSlti,
                                 kindAdd, kindSub, kindAnd, kindOr, kindSlt, kindSlt};
    int arithA [numArith] = '{100, -5, 1445, -256, -7, 9, 1234, -300, 2032, 291, -2, 5};
    int arithB [numArith] = '{-37, 2000, -16, 243, 3, -1, -2000, 700, -86, 1104, 5, -2};

    rv32iCore dut (
        .clk           (clk),
        .rstN          (rstN),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemReadData  (dmemReadData)
    );

    assign imemData     = imem[imemAddr[9:2]];
    assign dmemReadData = dmem[dmemAddr[9:2]];

    always @(posedge clk) begin
        if (dmemWrite) begin
            dmem[dmemAddr[9:2]] <= dmemWriteData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic rvIsaPkg::wordT encodeI(rvIsaPkg::opcodeT opcode, logic [2:0] f3,
                                               int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opcode};
    endfunction

    function automatic rvIsaPkg::wordT encodeR(logic [6:0] f7, int rs2, int rs1,
                                               logic [2:0] f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvIsaPkg::opRType};
    endfunction

    function automatic rvIsaPkg::wordT encodeS(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], rvIsaPkg::opStore};
    endfunction

    function automatic rvIsaPkg::wordT encodeB(int rs1, int rs2, int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], f3Beq, offset[4:1],
                offset[11], rvIsaPkg::opBranch};
    endfunction

    function automatic rvIsaPkg::wordT encodeJ(int rd, int offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0],
                rvIsaPkg::opJal};
    endfunction

    function automatic logic [2:0] funct3Of(int kind);
        logic [2:0] f3;
        case (kind)
            kindAndi, kindAnd: f3 = rvIsaPkg::f3And;
            kindOri, kindOr:   f3 = rvIsaPkg::f3Or;
            kindSlti, kindSlt: f3 = rvIsaPkg::f3Slt;
            default:           f3 = rvIsaPkg::f3AddSub;
        endcase
        return f3;
    endfunction

    // RV32I result of one table entry
    function automatic rvIsaPkg::wordT aluReference(int kind, int a, int b);
        rvIsaPkg::wordT res;
        case (kind)
            kindSub:           res = a - b;
            kindAndi, kindAnd: res = a & b;
            kindOri, kindOr:   res = a | b;
            kindSlti, kindSlt: res = (a < b) ? 32'd1 : 32'd0;  // signed compare
            default:           res = a + b;
        endcase
        return res;
    endfunction

    task automatic appendInstr(rvIsaPkg::wordT instr);
        prog.push_back(instr);
    endtask

    task automatic appendNops(int count);
        for (int i = 0; i < count; i++) begin
            prog.push_back(rvIsaPkg::nopInstr);
        end
    endtask

    // store a register to the next result slot and record what must arrive
    task automatic appendStore(int rs2, rvIsaPkg::wordT data);
        prog.push_back(encodeS(rs2, 0, nextAddr));
        expAddr.push_back(nextAddr);
        expData.push_back(data);
        nextAddr += 4;
    endtask

    task automatic buildProgram();
        int         kind;
        int         loadAddr;
        int         jalPc;
        logic [6:0] f7;
        nextAddr = 'h100;
        for (int k = 0; k < numArith; k++) begin
            kind = arithKind[k];
            appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 1, 0, arithA[k]));
            if (kind >= kindAdd) begin
                appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 3, 0, arithB[k]));
            end
            appendNops(2);  // producer to consumer gap
            if (kind >= kindAdd) begin
                f7 = (kind == kindSub) ? 7'b0100000 : 7'b0000000;
                appendInstr(encodeR(f7, 3, 1, funct3Of(kind), 2));
            end else begin
                appendInstr(encodeI(rvIsaPkg::opIType, funct3Of(kind), 2, 1, arithB[k]));
            end
            appendNops(2);
            appendStore(2, aluReference(kind, arithA[k], arithB[k]));
        end

        // store, load back, store the loaded word again
        appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 4, 0, -1234));
        appendNops(2);
        loadAddr = nextAddr;
        appendStore(4, -1234);
        appendInstr(encodeI(rvIsaPkg::opLoad, f3Word, 5, 0, loadAddr));
        appendNops(2);
        appendStore(5, -1234);

        // taken beq jumps over two stores
        appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 6, 0, 7));
        appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 7, 0, 7));
        appendNops(2);
        appendInstr(encodeB(6, 7, 12));
        appendInstr(encodeS(6, 0, skipBase));
        appendInstr(encodeS(6, 0, skipBase + 4));
        appendStore(7, 32'd7);

        appendInstr(encodeI(rvIsaPkg::opIType, rvIsaPkg::f3AddSub, 8, 0, 3));
        appendNops(2);
        appendInstr(encodeB(6, 8, 8));  // 7 != 3 so it falls through
        appendStore(8, 32'd3);

        jalPc = prog.size() * 4;
        appendInstr(encodeJ(1, 12));
        appendInstr(encodeS(6, 0, skipBase + 8));
        appendInstr(encodeS(6, 0, skipBase + 12));
        appendStore(1, jalPc + 4);  // link address
        appendInstr(encodeJ(0, 0));  // park here
    endtask

    task automatic fillMemories();
        for (int i = 0; i < 256; i++) begin
            if (i < prog.size()) begin
                imem[i] = prog[i];
            end else begin
                imem[i] = rvIsaPkg::nopInstr;
            end
            dmem[i] = {16'hda7a, 6'b0, i[7:0], 2'b00};
        end
    endtask

    task automatic checkIdle(string when);
        if (dmemWrite !== 1'b0) begin
            $display("Fail dmemWrite %s expected %h got %h", when, 1'b0, dmemWrite);
            errors++;
        end
        if (imemAddr !== 32'h0) begin
            $display("Fail imemAddr %s expected %h got %h", when, 32'h0, imemAddr);
            errors++;
        end
    endtask

    task automatic waitForStore(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < storeTimeout) begin
            @(negedge clk);
            if (dmemWrite === 1'b1) begin
                seen = 1'b1;
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic checkStore(int n);
        if (dmemAddr >= skipBase) begin
            $display("store %0d went to %h, a store that should have been skipped",
                     n, dmemAddr);
            errors++;
        end
        if (dmemAddr !== expAddr[n]) begin
            $display("Fail dmemAddr store %0d expected %h got %h", n, expAddr[n], dmemAddr);
            errors++;
        end
        if (dmemWriteData !== expData[n]) begin
            $display("Fail dmemWriteData store %0d expected %h got %h",
                     n, expData[n], dmemWriteData);
            errors++;
        end
    endtask

    task automatic watchForExtraStores();
        for (int i = 0; i < quietCycles; i++) begin
            @(negedge clk);
            if (dmemWrite === 1'b1) begin
                $display("unexpected store to address %h after the last expected one",
                         dmemAddr);
                errors++;
            end
        end
    endtask

    initial begin
        logic seen;
        int   n;
        errors = 0;
        rstN = 1'b1;
        buildProgram();
        fillMemories();
        #1 rstN = 1'b0;  // falling edge for the async reset
        repeat (2) begin
            @(posedge clk);
            #1;
            checkIdle("during reset");
        end
        rstN = 1'b1;
        @(negedge clk);
        checkIdle("after reset");

        n = 0;
        seen = 1'b1;
        while (seen && n < expAddr.size()) begin
            waitForStore(seen);
            if (!seen) begin
                $display("store %0d never happened", n);
                errors++;
            end else begin
                checkStore(n);
                n++;
            end
        end
        if (seen) begin
            watchForExtraStores();
        end

        $display("%0d errors, %0d of %0d stores seen", errors, n, expAddr.size());
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
logic/rvIsaPkg.sv
logic/rvPipePkg.sv
logic/stageIfs.sv
logic/fetchStage.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/rv32iCore.sv
dv/rv32iCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module rv32iCoreTb \
    -f files.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "^TEST OK$" sim.log; then
    exit 0
else
    exit 1
fi
